/* Makefile */
# Verilator build and run for the FIFO packet bridge testbench

TOP       ?= ft_packet_bridge_tb
FILELIST  ?= ft_packet_bridge.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: TOP FILELIST LOG OBJ_DIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ft_packet_bridge.f */
hdl/ft_bridge_pkg.sv
hdl/ft_read_port.sv
hdl/packet_receiver.sv
hdl/payload_ram.sv
hdl/reply_sequencer.sv
hdl/ft_write_port.sv
hdl/ft_packet_bridge.sv
tb/ft_packet_bridge_tb.sv

/* hdl/ft_bridge_pkg.sv */
// Types, framing symbols, FIFO cycle timing and FSM states shared by all bridge modules
package ft_bridge_pkg;

	// ====================
	// Data types
	// ====================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;

	// ====================
	// Packet framing
	// ====================
	localparam byte_t HEADER_SYMBOL  = 8'h55;
	localparam int    HEADER_COUNT   = 12;
	localparam byte_t TRAILER_SYMBOL = 8'hAA;
	localparam int    TRAILER_COUNT  = 8;
	localparam byte_t ERROR_SYMBOL   = 8'hEE;
	// Length + service + trailer, i.e. a packet with no payload
	localparam int    MIN_LENGTH     = 12;

	// ====================
	// FT245R cycle timing
	// ====================
	// Read cycle ticks
	localparam int RD_STROBE_START = 2;
	localparam int RD_STROBE_STOP  = 12;
	localparam int RD_SAMPLE       = 9;
	localparam int RD_END          = 25;

	// Write cycle ticks
	localparam int WR_OE_START     = 2;
	localparam int WR_STROBE_START = 5;
	localparam int WR_STROBE_STOP  = 15;
	localparam int WR_OE_STOP      = 22;
	localparam int WR_END          = 25;

	// Receiver and reply FSM states
	typedef enum logic [2:0] {
		RX_HUNT, RX_LEN_LO, RX_LEN_HI, RX_SVC_LO, RX_SVC_HI, RX_BODY
	} rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE, TX_HEADER, TX_LENGTH, TX_SERVICE, TX_PAYLOAD, TX_TRAILER
	} tx_state_t;

endpackage

/* hdl/ft_packet_bridge.sv */
// Top level of the USB FIFO packet bridge: read port, parser, RAM, reply and write port
`timescale 1ns/1ps

module ft_packet_bridge
	import ft_bridge_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 10
)(
	input  logic  clk,
	input  logic  reset,
	input  logic  ft_rxf_n,
	output logic  ft_rd_n,
	input  byte_t ft_data_in,
	input  logic  ft_txe_n,
	output logic  ft_wr,
	output byte_t ft_data_out,
	output logic  ft_data_oe,
	output logic  usb_active,
	output logic  packet_active
);

	// Read port to parser
	byte_t                     rx_byte;
	logic                      rx_valid;
	logic                      rd_active;

	// Parser to RAM and reply
	logic [RAM_ADDR_WIDTH-1:0] wr_addr;
	word_t                     wr_data;
	logic                      wr_en;
	word_t                     pkt_length;
	word_t                     pkt_service;
	logic                      pkt_error;
	logic                      pkt_done;

	// Reply side
	logic [RAM_ADDR_WIDTH-1:0] rd_addr;
	word_t                     rd_data;
	byte_t                     tx_byte;
	logic                      tx_start;
	logic                      tx_busy;

	// Any FIFO cycle in progress
	assign usb_active = rd_active | tx_busy;

	ft_read_port ft_read_port_inst (
		.clk        (clk),
		.reset      (reset),
		.ft_rxf_n   (ft_rxf_n),
		.ft_data_in (ft_data_in),
		.ft_rd_n    (ft_rd_n),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.rd_active  (rd_active)
	);

	packet_receiver #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) packet_receiver_inst (
		.clk           (clk),
		.reset         (reset),
		.rx_byte       (rx_byte),
		.rx_valid      (rx_valid),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.wr_en         (wr_en),
		.pkt_length    (pkt_length),
		.pkt_service   (pkt_service),
		.pkt_error     (pkt_error),
		.pkt_done      (pkt_done),
		.packet_active (packet_active)
	);

	payload_ram #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) payload_ram_inst (
		.clk     (clk),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	reply_sequencer #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) reply_sequencer_inst (
		.clk         (clk),
		.reset       (reset),
		.pkt_length  (pkt_length),
		.pkt_service (pkt_service),
		.pkt_error   (pkt_error),
		.pkt_done    (pkt_done),
		.ft_txe_n    (ft_txe_n),
		.tx_busy     (tx_busy),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.tx_byte     (tx_byte),
		.tx_start    (tx_start)
	);

	ft_write_port ft_write_port_inst (
		.clk         (clk),
		.reset       (reset),
		.tx_byte     (tx_byte),
		.tx_start    (tx_start),
		.tx_busy     (tx_busy),
		.ft_wr       (ft_wr),
		.ft_data_out (ft_data_out),
		.ft_data_oe  (ft_data_oe)
	);

endmodule

/* hdl/ft_read_port.sv */
// FIFO read side: synchronises RXF# and runs one timed read cycle per received byte
`timescale 1ns/1ps

module ft_read_port
	import ft_bridge_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  ft_rxf_n,
	input  byte_t ft_data_in,
	output logic  ft_rd_n,
	output byte_t rx_byte,
	output logic  rx_valid,
	output logic  rd_active
);

	// Strobe flop switches one tick ahead of the tick it shows
	localparam logic [4:0] STROBE_ON  = 5'(RD_STROBE_START - 1);
	localparam logic [4:0] STROBE_OFF = 5'(RD_STROBE_STOP - 1);
	localparam logic [4:0] SAMPLE     = 5'(RD_SAMPLE);
	localparam logic [4:0] CYCLE_END  = 5'(RD_END);

	logic       rxf_meta;
	logic       rxf_sync;
	logic       rxf_prev;
	logic       start_read;
	logic [4:0] tick;

	// Two-flop synchroniser, then one more stage for edge history
	always_ff @(posedge clk) begin
		if (reset) begin
			rxf_meta <= 1'b1;
			rxf_sync <= 1'b1;
			rxf_prev <= 1'b1;
		end else begin
			rxf_meta <= ft_rxf_n;
			rxf_sync <= rxf_meta;
			rxf_prev <= rxf_sync;
		end
	end

	// Falling edge of RXF#, dropped while a cycle runs
	assign start_read = rxf_prev & ~rxf_sync & ~rd_active;

	// ====================
	// Read cycle timer
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_active <= 1'b0;
			tick      <= '0;
			ft_rd_n   <= 1'b1;
			rx_valid  <= 1'b0;
		end else begin
			// Pulse in the tick after the sample
			rx_valid <= rd_active && (tick == SAMPLE);
			if (start_read) begin
				rd_active <= 1'b1;
				tick      <= '0;
			end else if (rd_active) begin
				if (tick == CYCLE_END) begin
					rd_active <= 1'b0;
					tick      <= '0;
				end else begin
					tick <= tick + 1'b1;
				end
			end
			// RD# low window
			if (rd_active && (tick == STROBE_ON))
				ft_rd_n <= 1'b0;
			else if (tick == STROBE_OFF)
				ft_rd_n <= 1'b1;
		end
	end

	// Data bus latch at the sample tick
	always_ff @(posedge clk) begin
		if (rd_active && (tick == SAMPLE))
			rx_byte <= ft_data_in;
	end

endmodule

/* hdl/ft_write_port.sv */
// FIFO write side: one timed write cycle per byte with WR strobe and data output enable
`timescale 1ns/1ps

module ft_write_port
	import ft_bridge_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  byte_t tx_byte,
	input  logic  tx_start,
	output logic  tx_busy,
	output logic  ft_wr,
	output byte_t ft_data_out,
	output logic  ft_data_oe
);

	// Output flops switch one tick ahead of the tick they show
	localparam logic [4:0] OE_ON      = 5'(WR_OE_START - 1);
	localparam logic [4:0] OE_OFF     = 5'(WR_OE_STOP - 1);
	localparam logic [4:0] STROBE_ON  = 5'(WR_STROBE_START - 1);
	localparam logic [4:0] STROBE_OFF = 5'(WR_STROBE_STOP - 1);
	localparam logic [4:0] CYCLE_END  = 5'(WR_END);

	logic       wr_active;
	logic [4:0] tick;

	// Busy from the start pulse to the end of the cycle
	assign tx_busy = wr_active | tx_start;

	// ====================
	// Write cycle timer
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_active  <= 1'b0;
			tick       <= '0;
			ft_wr      <= 1'b0;
			ft_data_oe <= 1'b0;
		end else begin
			if (tx_start && !wr_active) begin
				wr_active <= 1'b1;
				tick      <= '0;
			end else if (wr_active) begin
				if (tick == CYCLE_END) begin
					wr_active <= 1'b0;
					tick      <= '0;
				end else begin
					tick <= tick + 1'b1;
				end
			end
			// Output enable window
			if (wr_active && (tick == OE_ON))
				ft_data_oe <= 1'b1;
			else if (tick == OE_OFF)
				ft_data_oe <= 1'b0;
			// WR strobe, inside the enable window
			if (wr_active && (tick == STROBE_ON))
				ft_wr <= 1'b1;
			else if (tick == STROBE_OFF)
				ft_wr <= 1'b0;
		end
	end

	// Data held for the whole cycle
	always_ff @(posedge clk) begin
		if (tx_start && !wr_active)
			ft_data_out <= tx_byte;
	end

endmodule

/* hdl/packet_receiver.sv */
// Packet parser: finds header and trailer, checks length rules and stores payload words
`timescale 1ns/1ps

module packet_receiver
	import ft_bridge_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 10
)(
	input  logic                      clk,
	input  logic                      reset,
	input  byte_t                     rx_byte,
	input  logic                      rx_valid,
	output logic [RAM_ADDR_WIDTH-1:0] wr_addr,
	output word_t                     wr_data,
	output logic                      wr_en,
	output word_t                     pkt_length,
	output word_t                     pkt_service,
	output logic                      pkt_error,
	output logic                      pkt_done,
	output logic                      packet_active
);

	// Payload capacity in bytes
	localparam int         RAM_BYTES = 2 * (2 ** RAM_ADDR_WIDTH);
	localparam logic [3:0] HDR_LAST  = 4'(HEADER_COUNT - 1);
	localparam logic [2:0] TRL_LAST  = 3'(TRAILER_COUNT - 1);

	rx_state_t                 state;
	logic [3:0]                hdr_cnt;
	logic [2:0]                trl_cnt;
	word_t                     byte_cnt;
	byte_t                     len_lo;
	byte_t                     svc_lo;
	byte_t                     data_lo;
	word_t                     len_full;
	logic                      len_bad;
	logic                      in_payload;
	logic [RAM_ADDR_WIDTH-1:0] word_addr;

	// Length as soon as its high byte arrives
	assign len_full = {rx_byte, len_lo};

	// Too short, odd, or payload larger than the RAM
	assign len_bad = (int'(len_full) < MIN_LENGTH) || len_full[0] ||
		((int'(len_full) - MIN_LENGTH) > RAM_BYTES);

	// Byte index still before the trailer
	assign in_payload = (byte_cnt < (pkt_length - word_t'(TRAILER_COUNT)));

	assign packet_active = (state != RX_HUNT);

	// ====================
	// Framing FSM
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= RX_HUNT;
			hdr_cnt   <= '0;
			trl_cnt   <= '0;
			byte_cnt  <= '0;
			word_addr <= '0;
			pkt_error <= 1'b0;
			pkt_done  <= 1'b0;
			wr_en     <= 1'b0;
		end else begin
			pkt_done <= 1'b0;
			wr_en    <= 1'b0;
			if (rx_valid) begin
				// Bytes after the header
				if (state != RX_HUNT)
					byte_cnt <= byte_cnt + 1'b1;
				case (state)
					RX_HUNT: begin
						// Consecutive header symbols only
						if (rx_byte == HEADER_SYMBOL) begin
							if (hdr_cnt == HDR_LAST) begin
								state     <= RX_LEN_LO;
								hdr_cnt   <= '0;
								trl_cnt   <= '0;
								byte_cnt  <= '0;
								word_addr <= '0;
								pkt_error <= 1'b0;
							end else begin
								hdr_cnt <= hdr_cnt + 1'b1;
							end
						end else begin
							hdr_cnt <= '0;
						end
					end
					RX_LEN_LO: state <= RX_LEN_HI;
					RX_LEN_HI: begin
						if (len_bad)
							pkt_error <= 1'b1;
						state <= RX_SVC_LO;
					end
					RX_SVC_LO: state <= RX_SVC_HI;
					RX_SVC_HI: state <= RX_BODY;
					RX_BODY: begin
						// More bytes than the length allows
						if (byte_cnt >= pkt_length)
							pkt_error <= 1'b1;
						// Odd index holds the high byte of a word
						if (!pkt_error && in_payload && byte_cnt[0]) begin
							wr_en     <= 1'b1;
							word_addr <= word_addr + 1'b1;
						end
						if (rx_byte == TRAILER_SYMBOL) begin
							if (trl_cnt == TRL_LAST) begin
								pkt_done <= 1'b1;
								state    <= RX_HUNT;
								trl_cnt  <= '0;
							end else begin
								trl_cnt <= trl_cnt + 1'b1;
							end
						end else begin
							trl_cnt <= '0;
						end
					end
					default: state <= RX_HUNT;
				endcase
			end
		end
	end

	// Field and payload registers
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			case (state)
				RX_LEN_LO: len_lo <= rx_byte;
				RX_LEN_HI: pkt_length <= len_full;
				RX_SVC_LO: svc_lo <= rx_byte;
				RX_SVC_HI: pkt_service <= {rx_byte, svc_lo};
				RX_BODY: begin
					// Low byte first, word completes on the high byte
					if (!byte_cnt[0]) begin
						data_lo <= rx_byte;
					end else begin
						wr_data <= {rx_byte, data_lo};
						wr_addr <= word_addr;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* hdl/payload_ram.sv */
// Simple dual-port payload store, one write port and one registered read port
`timescale 1ns/1ps

module payload_ram
	import ft_bridge_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 10
)(
	input  logic                      clk,
	input  logic [RAM_ADDR_WIDTH-1:0] wr_addr,
	input  word_t                     wr_data,
	input  logic                      wr_en,
	input  logic [RAM_ADDR_WIDTH-1:0] rd_addr,
	output word_t                     rd_data
);

	localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;

	word_t mem [DEPTH];

	// Write port, receiver side
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read port, one cycle latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/reply_sequencer.sv */
// Reply builder: paces write cycles and picks each reply byte from its frame position
`timescale 1ns/1ps

module reply_sequencer
	import ft_bridge_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 10
)(
	input  logic                      clk,
	input  logic                      reset,
	input  word_t                     pkt_length,
	input  word_t                     pkt_service,
	input  logic                      pkt_error,
	input  logic                      pkt_done,
	input  logic                      ft_txe_n,
	input  logic                      tx_busy,
	output logic [RAM_ADDR_WIDTH-1:0] rd_addr,
	input  word_t                     rd_data,
	output byte_t                     tx_byte,
	output logic                      tx_start
);

	localparam word_t HDR_LAST    = word_t'(HEADER_COUNT - 1);
	localparam word_t TRL_LAST    = word_t'(TRAILER_COUNT - 1);
	// Length of a reply with no payload
	localparam word_t FRAME_BYTES = word_t'(MIN_LENGTH);

	tx_state_t  state;
	word_t      pos;
	word_t      reply_length;
	word_t      reply_service;
	word_t      payload_bytes;
	logic       txe_q;
	logic [1:0] gap_cnt;
	logic       fire;
	byte_t      next_byte;

	// Start a write once idle long enough and the FIFO has room
	assign fire = (state != TX_IDLE) && !tx_busy && !txe_q && (gap_cnt == 2'd2);

	// TXE# register and idle gap counter
	always_ff @(posedge clk) begin
		if (reset) begin
			txe_q   <= 1'b1;
			gap_cnt <= '0;
		end else begin
			txe_q <= ft_txe_n;
			if (tx_busy)
				gap_cnt <= '0;
			else if (gap_cnt != 2'd2)
				gap_cnt <= gap_cnt + 1'b1;
		end
	end

	// Byte for the current frame position
	always_comb begin
		case (state)
			TX_HEADER:  next_byte = HEADER_SYMBOL;
			TX_LENGTH:  next_byte = pos[0] ? reply_length[15:8] : reply_length[7:0];
			TX_SERVICE: next_byte = pos[0] ? reply_service[15:8] : reply_service[7:0];
			TX_PAYLOAD: next_byte = pos[0] ? rd_data[15:8] : rd_data[7:0];
			TX_TRAILER: next_byte = TRAILER_SYMBOL;
			default:    next_byte = '0;
		endcase
	end

	// ====================
	// Reply FSM
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= TX_IDLE;
			pos      <= '0;
			tx_start <= 1'b0;
			rd_addr  <= '0;
		end else begin
			tx_start <= fire;
			case (state)
				TX_IDLE: begin
					// New packets only between replies
					if (pkt_done) begin
						state   <= TX_HEADER;
						pos     <= '0;
						rd_addr <= '0;
					end
				end
				TX_HEADER: begin
					if (fire) begin
						if (pos == HDR_LAST) begin
							state <= TX_LENGTH;
							pos   <= '0;
						end else begin
							pos <= pos + 1'b1;
						end
					end
				end
				TX_LENGTH: begin
					if (fire) begin
						if (pos[0]) begin
							state <= TX_SERVICE;
							pos   <= '0;
						end else begin
							pos <= pos + 1'b1;
						end
					end
				end
				TX_SERVICE: begin
					if (fire) begin
						if (pos[0]) begin
							state <= (payload_bytes == '0) ? TX_TRAILER : TX_PAYLOAD;
							pos   <= '0;
						end else begin
							pos <= pos + 1'b1;
						end
					end
				end
				TX_PAYLOAD: begin
					if (fire) begin
						// High byte sent, fetch the next word ahead
						if (pos[0])
							rd_addr <= rd_addr + 1'b1;
						if (pos == (payload_bytes - 1'b1)) begin
							state <= TX_TRAILER;
							pos   <= '0;
						end else begin
							pos <= pos + 1'b1;
						end
					end
				end
				TX_TRAILER: begin
					if (fire) begin
						if (pos == TRL_LAST) begin
							state <= TX_IDLE;
							pos   <= '0;
						end else begin
							pos <= pos + 1'b1;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Reply fields captured at packet end, error reply has no payload
	always_ff @(posedge clk) begin
		if ((state == TX_IDLE) && pkt_done) begin
			if (pkt_error) begin
				reply_length  <= FRAME_BYTES;
				reply_service <= {ERROR_SYMBOL, ERROR_SYMBOL};
				payload_bytes <= '0;
			end else begin
				reply_length  <= pkt_length;
				reply_service <= pkt_service;
				payload_bytes <= pkt_length - FRAME_BYTES;
			end
		end
		if (fire)
			tx_byte <= next_byte;
	end

endmodule

/* tb/ft_packet_bridge_tb.sv */
// Testbench that models the FT245R FIFO around the bridge and checks each packet reply
`timescale 1ns/1ps

module ft_packet_bridge_tb;

	localparam int CLK_PERIOD      = 40;
	localparam int RAM_ADDR_WIDTH  = 10;
	localparam int NUM_ROWS        = 6;
	localparam int IDLE_CHECK      = 20;
	// RXF# stays high while the read cycle runs on from tick 12 to tick 25
	localparam int RXF_HIGH_CYCLES = 15;
	localparam int MAX_STALL       = 32;
	// Longer than any stall plus the gap between write cycles
	localparam int QUIET_CYCLES    = MAX_STALL + 32;

	// Frame symbols
	localparam logic [7:0] SYNC_BYTE = 8'h55;
	localparam logic [7:0] END_BYTE  = 8'hAA;
	localparam logic [7:0] BAD_BYTE  = 8'hEE;
	localparam int         HEAD_LEN  = 12;
	localparam int         TAIL_LEN  = 8;
	// Length, service and trailer bytes only
	localparam int         BASE_LEN  = 12;

	// Stimulus row where a length override of 0 keeps the true length
	typedef struct packed {
		logic [15:0] service;
		logic [7:0]  payload_len;
		logic [15:0] length_override;
		logic [3:0]  noise_len;
		logic        stall;
		logic        expect_error;
	} row_t;

	logic       clk;
	logic       reset      = 1'b1;
	logic       ft_rxf_n   = 1'b1;
	logic [7:0] ft_data_in = 8'h00;
	logic       ft_txe_n   = 1'b0;
	logic       ft_rd_n;
	logic       ft_wr;
	logic [7:0] ft_data_out;
	logic       ft_data_oe;
	logic       usb_active;
	logic       packet_active;

	// Offered bytes plus the expected and captured reply
	logic [7:0]  pkt_q [$];
	logic [7:0]  exp_q [$];
	logic [7:0]  reply_q [$];

	logic [31:0] packet_seed  = 32'd82;
	logic [31:0] stall_seed   = 32'd82;
	logic        stall_enable = 1'b0;
	int          stall_left;
	logic        wr_prev;
	logic        txe_seen;

	ft_packet_bridge #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) ft_packet_bridge_inst (
		.clk           (clk),
		.reset         (reset),
		.ft_rxf_n      (ft_rxf_n),
		.ft_rd_n       (ft_rd_n),
		.ft_data_in    (ft_data_in),
		.ft_txe_n      (ft_txe_n),
		.ft_wr         (ft_wr),
		.ft_data_out   (ft_data_out),
		.ft_data_oe    (ft_data_oe),
		.usb_active    (usb_active),
		.packet_active (packet_active)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ====================
	// Stimulus table
	// ====================
	function automatic row_t table_row(input int idx);
		row_t row;
		case (idx)
			// Good packet with six payload bytes
			0: row = '{16'h0102, 8'd6, 16'd0, 4'd0, 1'b0, 1'b0};
			// Length 12 with no payload
			1: row = '{16'h0300, 8'd0, 16'd0, 4'd0, 1'b0, 1'b0};
			// Length too small
			2: row = '{16'h0405, 8'd0, 16'd8, 4'd0, 1'b0, 1'b1};
			// Odd length
			3: row = '{16'h0607, 8'd3, 16'd15, 4'd0, 1'b0, 1'b1};
			// Length shorter than the bytes sent
			4: row = '{16'h0809, 8'd6, 16'd14, 4'd0, 1'b0, 1'b1};
			// Noise ahead of the header and TXE# stalls in the reply
			default: row = '{16'h0A0B, 8'd10, 16'd0, 4'd5, 1'b1, 1'b0};
		endcase
		return row;
	endfunction

	// Bytes in both directions over the whole run
	function automatic int run_bytes();
		int   total;
		int   idx;
		row_t row;
		total = 0;
		for (idx = 0; idx < NUM_ROWS; idx++) begin
			row = table_row(idx);
			total += int'(row.noise_len) + HEAD_LEN + 4 + int'(row.payload_len) + TAIL_LEN;
			total += HEAD_LEN + BASE_LEN;
			if (!row.expect_error)
				total += int'(row.payload_len);
		end
		return total;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Random data byte that is never a framing symbol
	task automatic draw_byte(output logic [7:0] value);
		do begin
			packet_seed = xorshift32(packet_seed);
			value = packet_seed[7:0];
		end while ((value == SYNC_BYTE) || (value == END_BYTE));
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, got);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Packet bytes and the reply the bridge owes for them
	task automatic build_packet(input row_t row);
		logic [15:0] length;
		logic [7:0]  value;
		logic [7:0]  payload [$];
		int          i;
		pkt_q.delete();
		exp_q.delete();
		for (i = 0; i < int'(row.noise_len); i++) begin
			draw_byte(value);
			pkt_q.push_back(value);
		end
		for (i = 0; i < int'(row.payload_len); i++) begin
			draw_byte(value);
			payload.push_back(value);
		end
		if (row.length_override != 16'd0)
			length = row.length_override;
		else
			length = 16'(BASE_LEN + int'(row.payload_len));
		for (i = 0; i < HEAD_LEN; i++)
			pkt_q.push_back(SYNC_BYTE);
		// Both fields low byte first
		pkt_q.push_back(length[7:0]);
		pkt_q.push_back(length[15:8]);
		pkt_q.push_back(row.service[7:0]);
		pkt_q.push_back(row.service[15:8]);
		for (i = 0; i < payload.size(); i++)
			pkt_q.push_back(payload[i]);
		for (i = 0; i < TAIL_LEN; i++)
			pkt_q.push_back(END_BYTE);
		// Reply frame
		for (i = 0; i < HEAD_LEN; i++)
			exp_q.push_back(SYNC_BYTE);
		if (row.expect_error) begin
			exp_q.push_back(8'(BASE_LEN));
			exp_q.push_back(8'h00);
			exp_q.push_back(BAD_BYTE);
			exp_q.push_back(BAD_BYTE);
		end else begin
			exp_q.push_back(length[7:0]);
			exp_q.push_back(length[15:8]);
			exp_q.push_back(row.service[7:0]);
			exp_q.push_back(row.service[15:8]);
			for (i = 0; i < payload.size(); i++)
				exp_q.push_back(payload[i]);
		end
		for (i = 0; i < TAIL_LEN; i++)
			exp_q.push_back(END_BYTE);
	endtask

	// One FIFO read with RXF# low until RD# has come and gone
	task automatic offer_byte(input logic [7:0] value);
		@(posedge clk);
		ft_rxf_n <= 1'b0;
		@(posedge clk);
		while (ft_rd_n)
			@(posedge clk);
		ft_data_in <= value;
		while (!ft_rd_n)
			@(posedge clk);
		ft_rxf_n <= 1'b1;
		repeat (RXF_HIGH_CYCLES) @(posedge clk);
	endtask

	// Compare reply bytes as the write model captures them
	task automatic collect_reply();
		int         idx;
		logic [7:0] got;
		idx = 0;
		while (idx < exp_q.size()) begin
			@(posedge clk);
			while ((reply_q.size() != 0) && (idx < exp_q.size())) begin
				got = reply_q.pop_front();
				check_value($sformatf("ft_data_out (reply byte %0d)", idx), 32'(got),
					32'(exp_q[idx]));
				idx++;
			end
		end
	endtask

	// ====================
	// FIFO write side model
	// ====================
	always @(posedge clk) begin
		if (reset) begin
			wr_prev    <= 1'b0;
			txe_seen   <= 1'b0;
			stall_left <= 0;
			ft_txe_n   <= 1'b0;
		end else begin
			wr_prev  <= ft_wr;
			txe_seen <= ft_txe_n;
			// Strobe never while the FIFO reports full
			if (txe_seen)
				check_value("ft_wr while ft_txe_n high", 32'(ft_wr), 32'd0);
			// Byte taken on the falling strobe
			if (wr_prev && !ft_wr && ft_data_oe)
				reply_q.push_back(ft_data_out);
			if (stall_left != 0) begin
				stall_left <= stall_left - 1;
				if (stall_left == 1)
					ft_txe_n <= 1'b0;
			end else if (wr_prev && !ft_wr && stall_enable) begin
				// Random full stretch right after a write
				stall_seed = xorshift32(stall_seed);
				if (stall_seed[0]) begin
					ft_txe_n   <= 1'b1;
					stall_left <= 1 + int'(stall_seed[8:4]);
				end
			end
		end
	end

	initial begin : watchdog
		longint limit_ns;
		limit_ns = (longint'(run_bytes()) * 40 + 2000) * longint'(CLK_PERIOD);
		#(limit_ns);
		$display("Timeout after %0d ns, the bridge stopped making progress", limit_ns);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// ====================
	// Main sequence
	// ====================
	initial begin : main_sequence
		int   row_idx;
		int   i;
		int   quiet;
		row_t row;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// Idle bus after reset
		repeat (IDLE_CHECK) begin
			@(posedge clk);
			check_value("ft_rd_n", 32'(ft_rd_n), 32'd1);
			check_value("ft_wr", 32'(ft_wr), 32'd0);
			check_value("ft_data_oe", 32'(ft_data_oe), 32'd0);
			check_value("usb_active", 32'(usb_active), 32'd0);
			check_value("packet_active", 32'(packet_active), 32'd0);
		end
		for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
			row = table_row(row_idx);
			build_packet(row);
			stall_enable = row.stall;
			for (i = 0; i < pkt_q.size(); i++)
				offer_byte(pkt_q[i]);
			collect_reply();
		end
		// Bus must go quiet with nothing left over
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(posedge clk);
			if (usb_active || ft_txe_n)
				quiet = 0;
			else
				quiet++;
		end
		check_value("extra reply bytes", reply_q.size(), 0);
		$display("Simulation passed");
		$finish;
	end

endmodule
